/* hw/muldiv_settings.svh */
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// Operand and result width of the core
`define MULDIV_XLEN 32

// Adder width
// Room for the Booth times-two operand plus two sign guard bits
`define MULDIV_ADDER_W 35

// Each partial register holds one word plus a sign bit
`define MULDIV_PART_W 33

// Radix-4 Booth steps, the first one runs in the IDLE cycle
`define MULDIV_MUL_STEPS 16

// Non-restoring divide steps
`define MULDIV_DIV_STEPS 32

// Iteration counter, wide enough to reach the divide count
`define MULDIV_CNT_W 6

`endif

/* hw/muldiv_op_pkg.sv */
`default_nettype none

package muldiv_op_pkg;

  // Multiply view of funct3[1:0]
  typedef enum logic [1:0] {
    // MUL, low word
    LO  = 2'b00,
    // MULH, signed x signed
    HSS = 2'b01,
    // MULHSU, signed x unsigned
    HSU = 2'b10,
    // MULHU, unsigned x unsigned
    HUU = 2'b11
  } muldiv_mul_fn_e;

  // Divide view of funct3[1:0]
  typedef struct packed {
    // Set for REM and REMU
    logic rem;
    // Set for DIVU and REMU
    logic unsgn;
  } muldiv_div_fn_t;

  // Same two bits, read one way or the other by the top bit
  typedef union packed {
    muldiv_mul_fn_e mul;
    muldiv_div_fn_t div;
  } muldiv_fn_u;

  // funct3 of the OP opcode with funct7 = 0000001
  typedef struct packed {
    logic       muldiv_is_div;
    muldiv_fn_u fn;
  } muldiv_funct_t;

endpackage

`default_nettype wire

/* hw/muldiv_dp_pkg.sv */
`default_nettype none

`include "muldiv_settings.svh"

package muldiv_dp_pkg;

  // Sequencer phases
  typedef enum logic [2:0] {
    // Waiting, also runs the first iteration
    IDLE      = 3'd0,
    // Booth or non-restoring iterations
    EXEC      = 3'd1,
    // Divide only, does the remainder need fixing
    REMD_CHCK = 3'd2,
    // Divide only, quotient plus or minus one
    QUOT_CORR = 3'd3,
    // Divide only, remainder plus or minus the divisor
    REMD_CORR = 3'd4
  } muldiv_state_e;

  // The single adder word
  typedef logic [`MULDIV_ADDER_W-1:0] muldiv_adder_t;

  // Product halves, or remainder and quotient
  typedef logic [`MULDIV_PART_W-1:0] muldiv_part_t;

endpackage

`default_nettype wire

/* hw/muldiv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_decode
  import muldiv_op_pkg::*;
(
  input  wire [`MULDIV_XLEN-1:0]  i_rs1,
  input  wire [`MULDIV_XLEN-1:0]  i_rs2,
  input  wire muldiv_funct_t      i_funct3,
  output muldiv_funct_t           o_funct,
  output logic                    o_op1_sign,
  output logic                    o_op2_sign,
  output logic                    o_special,
  output logic [`MULDIV_XLEN-1:0] o_special_result
);

  logic rs1_is_min;
  logic div_by_0;
  logic div_ovf;

  assign o_funct = i_funct3;

  // Sign bit that extends each operand to 33 bits
  always_comb begin
    if (i_funct3.muldiv_is_div) begin
      // Unsigned divides see both operands as positive
      o_op1_sign = ~i_funct3.fn.div.unsgn & i_rs1[`MULDIV_XLEN-1];
      o_op2_sign = ~i_funct3.fn.div.unsgn & i_rs2[`MULDIV_XLEN-1];
    end else begin
      // Only MULHU takes rs1 as unsigned
      o_op1_sign = (i_funct3.fn.mul != HUU) & i_rs1[`MULDIV_XLEN-1];
      // MULHSU and MULHU take rs2 as unsigned
      o_op2_sign = ((i_funct3.fn.mul == LO) | (i_funct3.fn.mul == HSS))
                 & i_rs2[`MULDIV_XLEN-1];
    end
  end

  // Most negative integer, 0x8000_0000
  assign rs1_is_min = (i_rs1 == {1'b1, {(`MULDIV_XLEN-1){1'b0}}});

  // Zero divisor
  assign div_by_0 = ~(|i_rs2);

  // Signed min / -1 does not fit
  assign div_ovf = ~i_funct3.fn.div.unsgn & rs1_is_min & (&i_rs2);

  // Only divides have cases answered in cycle 0
  assign o_special = i_funct3.muldiv_is_div & (div_by_0 | div_ovf);

  // RISC-V defined answers
  always_comb begin
    if (div_by_0) begin
      // Quotient all ones, remainder is the dividend
      o_special_result = i_funct3.fn.div.rem ? i_rs1 : {`MULDIV_XLEN{1'b1}};
    end else begin
      // Quotient is the dividend itself, remainder zero
      o_special_result = i_funct3.fn.div.rem ? {`MULDIV_XLEN{1'b0}} : i_rs1;
    end
  end

endmodule

`default_nettype wire

/* hw/muldiv_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_sequencer
  import muldiv_dp_pkg::*;
(
  input  wire    clk,
  input  wire    i_reset,
  input  wire    i_valid,
  input  wire    i_special,
  input  wire    i_is_div,
  input  wire    i_need_corr,
  input  wire    i_handshake,
  output muldiv_state_e o_state,
  output logic   o_exec_last
);

  muldiv_state_e            state_q;
  muldiv_state_e            state_d;
  logic [`MULDIV_CNT_W-1:0] exec_cnt;
  logic                     last_cnt;
  logic                     cnt_set;
  logic                     cnt_inc;

  assign o_state = state_q;

  // Multiply stops at 16, divide at 32
  assign last_cnt = i_is_div ? (exec_cnt == `MULDIV_DIV_STEPS)
                             : (exec_cnt == `MULDIV_MUL_STEPS);
  assign o_exec_last = (state_q == EXEC) & last_cnt;

  // EXEC entry counts IDLE as the 0th step
  assign cnt_set = (state_q == IDLE) & i_valid & ~i_special;
  // Counter freezes on the last step while back-pressured
  assign cnt_inc = (state_q == EXEC) & ~last_cnt;

  //////////////////////////////////////////////////////////////////////
  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Special cases finish here without leaving IDLE
        if (i_valid & ~i_special) begin
          state_d = EXEC;
        end
      end
      EXEC: begin
        if (o_exec_last) begin
          // Divide always goes on to the check, multiply waits for the handshake
          if (i_is_div) begin
            state_d = REMD_CHCK;
          end else if (i_handshake) begin
            state_d = IDLE;
          end
        end
      end
      REMD_CHCK: begin
        if (i_need_corr) begin
          state_d = QUOT_CORR;
        end else if (i_handshake) begin
          state_d = IDLE;
        end
      end
      QUOT_CORR: begin
        state_d = REMD_CORR;
      end
      REMD_CORR: begin
        // Corrected remainder is driven straight from the adder here
        if (i_handshake) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q  <= IDLE;
      exec_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (cnt_set) begin
        exec_cnt <= {{(`MULDIV_CNT_W-1){1'b0}}, 1'b1};
      end else if (cnt_inc) begin
        exec_cnt <= exec_cnt + 1'b1;
      end
    end
  end

  // Check and correction phases belong to a divide only
  a_corr_div_only: assert property (@(posedge clk) disable iff (i_reset)
    (state_q inside {REMD_CHCK, QUOT_CORR, REMD_CORR}) |-> i_is_div);

  // Counter never runs past the divide step count
  a_cnt_bound: assert property (@(posedge clk) disable iff (i_reset)
    exec_cnt <= `MULDIV_DIV_STEPS);

endmodule

`default_nettype wire

/* hw/muldiv_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_datapath
  import muldiv_op_pkg::*;
  import muldiv_dp_pkg::*;
(
  input  wire                     clk,
  input  wire                     i_reset,
  input  wire [`MULDIV_XLEN-1:0]  i_rs1,
  input  wire [`MULDIV_XLEN-1:0]  i_rs2,
  input  wire muldiv_funct_t      i_funct,
  input  wire                     i_op1_sign,
  input  wire                     i_op2_sign,
  input  wire muldiv_state_e      i_state,
  input  wire                     i_exec_last,
  output logic                    o_need_corr,
  output logic [`MULDIV_XLEN-1:0] o_prod_lo,
  output logic [`MULDIV_XLEN-1:0] o_prod_hi,
  output logic [`MULDIV_XLEN-1:0] o_quot,
  output logic [`MULDIV_XLEN-1:0] o_remd
);

  logic          is_div;
  logic          st_idle;
  logic          st_exec;
  logic          st_qcorr;
  logic          st_rcorr;
  // Shared registers, product hi/lo or remainder/quotient
  muldiv_part_t  part_hi_q;
  muldiv_part_t  part_lo_q;
  muldiv_part_t  part_hi_d;
  muldiv_part_t  part_lo_d;
  logic          part_hi_en;
  logic          part_lo_en;
  logic          prdt_sft1_q;
  logic          remd_sft1_q;
  muldiv_adder_t add_op1;
  muldiv_adder_t add_op2;
  muldiv_adder_t add_res;
  logic          add_sub;
  logic [2:0]    booth_code;
  logic          booth_zero;
  logic          booth_two;
  muldiv_adder_t mul_op1;
  muldiv_adder_t mul_op2;
  logic [33:0]   divisor;
  logic          quot_0cycl;
  logic          prev_quot;
  logic          curr_quot;
  logic [66:0]   div_part;
  logic [67:0]   div_part_lsft1;
  logic          remd_is_0;
  logic          remd_is_divs;
  logic          remd_is_neg_divs;
  logic          remd_inc_quot_dec;

  assign is_div   = i_funct.muldiv_is_div;
  assign st_idle  = (i_state == IDLE);
  assign st_exec  = (i_state == EXEC);
  assign st_qcorr = (i_state == QUOT_CORR);
  assign st_rcorr = (i_state == REMD_CORR);

  // One adder for every phase, subtract as invert plus carry in
  assign add_res = add_op1 + (add_op2 ^ {`MULDIV_ADDER_W{add_sub}})
                 + muldiv_adder_t'(add_sub);

  //////////////////////////////////////////////////////////////////////
  // Radix-4 Booth multiply
  // Multiplier bits come from rs1 in IDLE, then shift out of part_lo
  // Last step recodes with the sign so signed and unsigned both work
  assign booth_code = st_idle     ? {i_rs1[1:0], 1'b0}
                    : i_exec_last ? {i_op1_sign, part_lo_q[0], prdt_sft1_q}
                    :               {part_lo_q[1:0], prdt_sft1_q};

  // 000 and 111 add nothing, 011 and 100 take twice rs2
  assign booth_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign booth_two  = (booth_code == 3'b011) | (booth_code == 3'b100);

  always_comb begin
    if (booth_zero) begin
      mul_op2 = '0;
    end else if (booth_two) begin
      mul_op2 = {i_op2_sign, i_op2_sign, i_rs2, 1'b0};
    end else begin
      mul_op2 = {i_op2_sign, i_op2_sign, i_op2_sign, i_rs2};
    end
  end

  // Accumulator starts from zero
  assign mul_op1 = st_idle ? '0 : {part_hi_q[32], part_hi_q[32], part_hi_q};

  //////////////////////////////////////////////////////////////////////
  // Non-restoring divide
  assign divisor = {i_op2_sign, i_op2_sign, i_rs2};

  // First quotient digit is +1 when the signs agree
  assign quot_0cycl = ~(i_op1_sign ^ i_op2_sign);
  assign prev_quot  = st_idle ? quot_0cycl : part_lo_q[0];
  assign curr_quot  = ~(add_res[33] ^ i_op2_sign);

  // Remainder on top, pending dividend bits and quotient below
  assign div_part       = {add_res[33:0], (st_idle ? {i_rs1, quot_0cycl} : part_lo_q)};
  assign div_part_lsft1 = {div_part, curr_quot};

  // Correction check, valid in REMD_CHCK where the adder forms remd + divisor
  assign remd_is_0         = ~(|part_hi_q);
  assign remd_is_neg_divs  = ~(|add_res[33:0]);
  assign remd_is_divs      = (part_hi_q == divisor[32:0]);
  assign remd_inc_quot_dec = part_hi_q[32] ^ i_op2_sign;

  assign o_need_corr = is_div & (((part_hi_q[32] ^ i_op1_sign) & ~remd_is_0)
                     | remd_is_neg_divs | remd_is_divs);

  // Adder operands per phase
  always_comb begin
    add_op1 = mul_op1;
    add_op2 = mul_op2;
    add_sub = booth_code[2];
    if (is_div) begin
      case (i_state)
        REMD_CHCK: begin
          add_op1 = {1'b0, part_hi_q[32], part_hi_q};
          add_op2 = {1'b0, divisor};
          add_sub = 1'b0;
        end
        QUOT_CORR: begin
          add_op1 = {1'b0, part_lo_q[32], part_lo_q};
          add_op2 = muldiv_adder_t'(1);
          add_sub = remd_inc_quot_dec;
        end
        REMD_CORR: begin
          add_op1 = {1'b0, part_hi_q[32], part_hi_q};
          add_op2 = {1'b0, divisor};
          add_sub = ~remd_inc_quot_dec;
        end
        default: begin
          // IDLE starts from the sign-extended dividend top
          add_op1 = st_idle ? {1'b0, {34{i_op1_sign}}} : {1'b0, remd_sft1_q, part_hi_q};
          add_op2 = {1'b0, divisor};
          add_sub = prev_quot;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Partial registers
  // Last multiply step stays combinational so back-pressure holds state
  assign part_hi_en = st_idle | (st_exec & (is_div | ~i_exec_last));
  assign part_lo_en = part_hi_en | st_qcorr;

  always_comb begin
    if (!is_div) begin
      part_hi_d = add_res[34:2];
      part_lo_d = {add_res[1:0], (st_idle ? {i_op1_sign, i_rs1[31:2]} : part_lo_q[32:2])};
    end else if (st_qcorr) begin
      part_hi_d = part_hi_q;
      part_lo_d = add_res[32:0];
    end else if (i_exec_last) begin
      // Remainder unshifted, final quotient digit forced to one
      part_hi_d = div_part[65:33];
      part_lo_d = {div_part[31:0], 1'b1};
    end else begin
      part_hi_d = div_part_lsft1[65:33];
      part_lo_d = div_part_lsft1[32:0];
    end
  end

  always_ff @(posedge clk) begin
    if (part_hi_en) begin
      part_hi_q   <= part_hi_d;
      prdt_sft1_q <= st_idle ? i_rs1[1] : part_lo_q[1];
      // Adder bit that drops out of the 33-bit remainder
      remd_sft1_q <= add_res[32];
    end
    if (part_lo_en) begin
      part_lo_q <= part_lo_d;
    end
  end

  assign o_prod_lo = part_lo_q[32:1];
  // High word is the last Booth step
  assign o_prod_hi = add_res[31:0];
  assign o_quot    = part_lo_q[31:0];
  assign o_remd    = st_rcorr ? add_res[31:0] : part_hi_q[31:0];

  // Decode must keep zero divisors out of the iterations
  a_div_nonzero: assert property (@(posedge clk) disable iff (i_reset)
    (st_exec & is_div) |-> (i_rs2 != '0));

endmodule

`default_nettype wire

/* hw/muldiv_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_result
  import muldiv_op_pkg::*;
  import muldiv_dp_pkg::*;
(
  input  wire                     i_valid,
  input  wire                     i_ready,
  input  wire muldiv_funct_t      i_funct,
  input  wire muldiv_state_e      i_state,
  input  wire                     i_exec_last,
  input  wire                     i_need_corr,
  input  wire                     i_special,
  input  wire [`MULDIV_XLEN-1:0]  i_special_result,
  input  wire [`MULDIV_XLEN-1:0]  i_prod_lo,
  input  wire [`MULDIV_XLEN-1:0]  i_prod_hi,
  input  wire [`MULDIV_XLEN-1:0]  i_quot,
  input  wire [`MULDIV_XLEN-1:0]  i_remd,
  output logic                    o_valid,
  output logic                    o_ready,
  output logic                    o_handshake,
  output logic [`MULDIV_XLEN-1:0] o_result
);

  logic wbck;

  // Special cases are ready at once and a multiply on its last step
  // A divide is ready after the check or after both corrections
  assign wbck = i_special
              | (i_exec_last & ~i_funct.muldiv_is_div)
              | ((i_state == REMD_CHCK) & ~i_need_corr)
              | (i_state == REMD_CORR);

  // Issue and writeback complete in the same cycle
  assign o_valid     = wbck & i_valid;
  assign o_ready     = wbck & i_ready;
  assign o_handshake = o_valid & i_ready;

  always_comb begin
    if (i_special) begin
      o_result = i_special_result;
    end else if (i_funct.muldiv_is_div) begin
      o_result = i_funct.fn.div.rem ? i_remd : i_quot;
    end else begin
      // Only MUL wants the low word
      o_result = (i_funct.fn.mul == LO) ? i_prod_lo : i_prod_hi;
    end
  end

endmodule

`default_nettype wire

/* hw/muldiv_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_unit
  import muldiv_op_pkg::*;
  import muldiv_dp_pkg::*;
(
  input  wire                     clk,
  input  wire                     i_reset,
  input  wire                     i_valid,
  input  wire [`MULDIV_XLEN-1:0]  i_rs1,
  input  wire [`MULDIV_XLEN-1:0]  i_rs2,
  input  wire muldiv_funct_t      i_funct3,
  input  wire                     i_ready,
  output logic                    o_ready,
  output logic                    o_valid,
  output logic [`MULDIV_XLEN-1:0] o_result
);

  muldiv_funct_t           funct;
  logic                    op1_sign;
  logic                    op2_sign;
  logic                    special;
  logic [`MULDIV_XLEN-1:0] special_result;
  muldiv_state_e           state;
  logic                    exec_last;
  logic                    need_corr;
  logic                    handshake;
  logic [`MULDIV_XLEN-1:0] prod_lo;
  logic [`MULDIV_XLEN-1:0] prod_hi;
  logic [`MULDIV_XLEN-1:0] quot;
  logic [`MULDIV_XLEN-1:0] remd;

  // Operation type, operand signs and divide special cases
  muldiv_decode decode_i (
    .i_rs1            (i_rs1),
    .i_rs2            (i_rs2),
    .i_funct3         (i_funct3),
    .o_funct          (funct),
    .o_op1_sign       (op1_sign),
    .o_op2_sign       (op2_sign),
    .o_special        (special),
    .o_special_result (special_result)
  );

  muldiv_sequencer sequencer_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_special   (special),
    .i_is_div    (funct.muldiv_is_div),
    .i_need_corr (need_corr),
    .i_handshake (handshake),
    .o_state     (state),
    .o_exec_last (exec_last)
  );

  // Adder and partial registers
  muldiv_datapath datapath_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_rs1       (i_rs1),
    .i_rs2       (i_rs2),
    .i_funct     (funct),
    .i_op1_sign  (op1_sign),
    .i_op2_sign  (op2_sign),
    .i_state     (state),
    .i_exec_last (exec_last),
    .o_need_corr (need_corr),
    .o_prod_lo   (prod_lo),
    .o_prod_hi   (prod_hi),
    .o_quot      (quot),
    .o_remd      (remd)
  );

  muldiv_result result_i (
    .i_valid          (i_valid),
    .i_ready          (i_ready),
    .i_funct          (funct),
    .i_state          (state),
    .i_exec_last      (exec_last),
    .i_need_corr      (need_corr),
    .i_special        (special),
    .i_special_result (special_result),
    .i_prod_lo        (prod_lo),
    .i_prod_hi        (prod_hi),
    .i_quot           (quot),
    .i_remd           (remd),
    .o_valid          (o_valid),
    .o_ready          (o_ready),
    .o_handshake      (handshake),
    .o_result         (o_result)
  );

endmodule

`default_nettype wire

/* testbench/muldiv_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_unit_tb
  import muldiv_op_pkg::*;
;

  localparam int XLEN = `MULDIV_XLEN;
  localparam logic [XLEN-1:0] MIN_INT = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MAX_INT = {1'b0, {(XLEN-1){1'b1}}};

  // Cycles from presentation in IDLE to o_valid
  localparam int MUL_LAT      = 16;
  localparam int DIV_LAT      = 33;
  localparam int DIV_CORR_LAT = 35;

  // Operation count sets the watchdog limit
  localparam int N_CORNER       = 5;
  localparam int N_RAND         = 50;
  localparam int NUM_OPS        = 4 * N_CORNER * N_CORNER + 8 * N_RAND + 4 + 4 + 5 + 3;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 100;

  logic            clk;
  logic            i_reset;
  logic            i_valid;
  logic [XLEN-1:0] i_rs1;
  logic [XLEN-1:0] i_rs2;
  muldiv_funct_t   i_funct3;
  logic            i_ready;
  logic            o_ready;
  logic            o_valid;
  logic [XLEN-1:0] o_result;

  integer          seed;
  int              errors;
  int              checks;
  int unsigned     cycle_cnt;

  muldiv_unit muldiv_unit_i (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_valid  (i_valid),
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .i_funct3 (i_funct3),
    .i_ready  (i_ready),
    .o_ready  (o_ready),
    .o_valid  (o_valid),
    .o_result (o_result)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout: no finish after %0d cycles, the DUT seems stuck", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic string op_name(input muldiv_funct_t fn);
    logic [2:0] code;
    code = fn;
    case (code)
      3'b000:  return "MUL";
      3'b001:  return "MULH";
      3'b010:  return "MULHSU";
      3'b011:  return "MULHU";
      3'b100:  return "DIV";
      3'b101:  return "DIVU";
      3'b110:  return "REM";
      default: return "REMU";
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model from the RISC-V M rules
  task automatic model_result(input muldiv_funct_t fn, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b, output logic [XLEN-1:0] exp);
    logic [2:0]        code;
    logic [2*XLEN-1:0] ext_a;
    logic [2*XLEN-1:0] ext_b;
    logic [2*XLEN-1:0] prod;
    int                sa;
    int                sb;
    code = fn;
    sa   = a;
    sb   = b;
    // rs1 unsigned only for MULHU, rs2 unsigned for MULHSU and MULHU
    ext_a = (code == 3'b011) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
    ext_b = (code[1] == 1'b1) ? {{XLEN{1'b0}}, b} : {{XLEN{b[XLEN-1]}}, b};
    prod  = ext_a * ext_b;
    case (code)
      3'b000: exp = prod[XLEN-1:0];
      3'b001, 3'b010, 3'b011: exp = prod[2*XLEN-1:XLEN];
      // Division truncates toward zero, remainder takes the dividend sign
      3'b100: begin
        if (b == '0) exp = '1;
        else if (a == MIN_INT && b == '1) exp = MIN_INT;
        else exp = sa / sb;
      end
      3'b101: exp = (b == '0) ? '1 : a / b;
      3'b110: begin
        if (b == '0) exp = a;
        else if (a == MIN_INT && b == '1) exp = '0;
        else exp = sa % sb;
      end
      default: exp = (b == '0) ? a : a % b;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  task automatic check_result(input muldiv_funct_t fn, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s rs1=%h rs2=%h result %h, expected %h",
               $time, op_name(fn), a, b, got, exp);
    end
  endtask

  task automatic check_latency(input muldiv_funct_t fn, input int got, input int lo,
                               input int hi);
    checks++;
    if (got != lo && got != hi) begin
      errors++;
      $display("[ERROR] %0t: %s took %0d cycles, expected %0d or %0d",
               $time, op_name(fn), got, lo, hi);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%-18s %s, %0d errors", name,
             (errors == errs_before) ? "ok" : "FAILED", errors - errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Present one operation with i_ready high and sample 1 ns after each falling edge
  task automatic run_op(input muldiv_funct_t fn, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, output logic [XLEN-1:0] res,
                        output int cycles);
    @(negedge clk);
    i_valid  = 1'b1;
    i_rs1    = a;
    i_rs2    = b;
    i_funct3 = fn;
    i_ready  = 1'b1;
    cycles   = 0;
    #1;
    while (!o_valid) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    res = o_result;
    check_flag("o_ready with i_ready high", o_ready, 1'b1);
    // Handshake at the next rising edge
    @(negedge clk);
    i_valid = 1'b0;
    i_ready = 1'b0;
  endtask

  // Run, compare against the model and against the expected latency
  task automatic exercise(input muldiv_funct_t fn, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    logic [XLEN-1:0] exp;
    logic [XLEN-1:0] got;
    logic [2:0]      code;
    int              cycles;
    code = fn;
    model_result(fn, a, b, exp);
    run_op(fn, a, b, got, cycles);
    check_result(fn, a, b, got, exp);
    if (code[2] && (b == '0 || (!code[0] && a == MIN_INT && b == '1))) begin
      check_latency(fn, cycles, 0, 0);
    end else if (code[2]) begin
      check_latency(fn, cycles, DIV_LAT, DIV_CORR_LAT);
    end else begin
      check_latency(fn, cycles, MUL_LAT, MUL_LAT);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  task automatic mul_corner_sweep();
    logic [XLEN-1:0] corner [N_CORNER];
    muldiv_funct_t   fn;
    int              errs;
    errs   = errors;
    corner = '{'0, 1, '1, MIN_INT, MAX_INT};
    for (int i = 0; i < N_CORNER; i++) begin
      for (int j = 0; j < N_CORNER; j++) begin
        for (int k = 0; k < 4; k++) begin
          fn = k[2:0];
          exercise(fn, corner[i], corner[j]);
        end
      end
    end
    report_test("mul_corners", errs);
  endtask

  task automatic mul_random_pairs();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    muldiv_funct_t   fn;
    int              errs;
    errs = errors;
    for (int i = 0; i < N_RAND; i++) begin
      a = $random(seed);
      b = $random(seed);
      for (int k = 0; k < 4; k++) begin
        fn = k[2:0];
        exercise(fn, a, b);
      end
    end
    report_test("mul_random", errs);
  endtask

  task automatic div_random_pairs();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    muldiv_funct_t   fn;
    int              errs;
    errs = errors;
    for (int i = 0; i < N_RAND; i++) begin
      a = $random(seed);
      b = $random(seed);
      case (i % 4)
        // Small divisor gives a long quotient
        1: b = b >> (i % 24);
        // Exact multiples
        2: begin
          b = (b & 32'h0000_ffff) | 1;
          a = b * ($random(seed) & 32'h0000_7fff);
        end
        3: begin
          b = (b & 32'h0000_ffff) | 1;
          a = -(b * ($random(seed) & 32'h0000_7fff));
        end
        default: ;
      endcase
      if (i % 8 == 7) b = -b;
      if (b == '0) b = 1;
      for (int k = 0; k < 4; k++) begin
        fn = 3'b100 | k[2:0];
        exercise(fn, a, b);
      end
    end
    report_test("div_random", errs);
  endtask

  // Zero divisor answered in cycle 0
  task automatic zero_divisor_cases();
    muldiv_funct_t fn;
    int            errs;
    errs = errors;
    for (int k = 0; k < 4; k++) begin
      fn = 3'b100 | k[2:0];
      exercise(fn, 32'hdead_beef, '0);
    end
    report_test("div_by_zero", errs);
  endtask

  task automatic signed_overflow_cases();
    int errs;
    errs = errors;
    exercise(3'b100, MIN_INT, '1);
    exercise(3'b110, MIN_INT, '1);
    // Same operands unsigned run the normal iterative divide
    exercise(3'b101, MIN_INT, '1);
    exercise(3'b111, MIN_INT, '1);
    report_test("div_overflow", errs);
  endtask

  task automatic latency_spot_checks();
    int errs;
    errs = errors;
    exercise(3'b000, 32'd3, 32'd5);
    exercise(3'b011, 32'hffff_0000, 32'h0001_0001);
    exercise(3'b100, 32'd100, 32'd7);
    exercise(3'b100, -32'sd100, 32'd7);
    exercise(3'b111, 32'd12, 32'd4);
    report_test("latency", errs);
  endtask

  // Hold i_ready low 10 cycles after o_valid
  task automatic stall_op(input muldiv_funct_t fn, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    logic [XLEN-1:0] exp;
    logic [XLEN-1:0] held;
    model_result(fn, a, b, exp);
    @(negedge clk);
    i_valid  = 1'b1;
    i_rs1    = a;
    i_rs2    = b;
    i_funct3 = fn;
    i_ready  = 1'b0;
    #1;
    while (!o_valid) begin
      @(negedge clk);
      #1;
    end
    held = o_result;
    check_result(fn, a, b, held, exp);
    check_flag("o_ready while stalled", o_ready, 1'b0);
    repeat (10) begin
      @(negedge clk);
      #1;
      check_flag("o_valid while stalled", o_valid, 1'b1);
      check_flag("o_ready while stalled", o_ready, 1'b0);
      check_result(fn, a, b, o_result, held);
    end
    @(negedge clk);
    i_ready = 1'b1;
    #1;
    check_flag("o_ready on release", o_ready, 1'b1);
    check_result(fn, a, b, o_result, exp);
    // Handshake at the next rising edge while i_ready stays high
    @(negedge clk);
    i_valid = 1'b0;
    #1;
    check_flag("o_ready one cycle after release", o_ready, 1'b0);
  endtask

  task automatic backpressure_hold();
    int errs;
    errs = errors;
    stall_op(3'b001, MIN_INT, MAX_INT);
    stall_op(3'b100, -32'sd1234567, 32'd89);
    // Next operation must see a clean IDLE
    exercise(3'b000, 32'h1234_5678, 32'h9abc_def0);
    report_test("backpressure", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  initial begin
    seed      = 32'h6dbc_9b58;
    clk       = 1'b0;
    i_reset   = 1'b1;
    i_valid   = 1'b0;
    i_rs1     = '0;
    i_rs2     = '0;
    i_funct3  = '0;
    i_ready   = 1'b0;
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    mul_corner_sweep();
    mul_random_pairs();
    div_random_pairs();
    zero_divisor_cases();
    signed_overflow_cases();
    latency_spot_checks();
    backpressure_hold();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/muldiv_op_pkg.sv
hw/muldiv_dp_pkg.sv
hw/muldiv_decode.sv
hw/muldiv_sequencer.sv
hw/muldiv_datapath.sv
hw/muldiv_result.sv
hw/muldiv_unit.sv
testbench/muldiv_unit_tb.sv

/* Bender.yml */
package:
  name: muldiv_unit

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/muldiv_op_pkg.sv
      - hw/muldiv_dp_pkg.sv
      - hw/muldiv_decode.sv
      - hw/muldiv_sequencer.sv
      - hw/muldiv_datapath.sv
      - hw/muldiv_result.sv
      - hw/muldiv_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/muldiv_unit_tb.sv
